// File: design/qsgmii_pkg.sv
package qsgmii_pkg;

	//////////////////////////////////////////////////
	// Link geometry

	// SGMII ports interleaved on one QSGMII link
	localparam int port_count = 4;

	// Lane number within a 32-bit word
	// Two bits so lane arithmetic wraps mod 4 for free
	typedef logic [1:0] lane_idx_t;

	//////////////////////////////////////////////////
	// Control code groups

	// Values are the decoded 8-bit bytes, flagged as control
	// by the transceiver

	// K28.5, the ordinary comma seen on every port
	localparam logic [7:0] k28_5 = 8'hbc;

	// K28.1, sent in place of K28.5 on port 0 only
	localparam logic [7:0] k28_1 = 8'h3c;

	//////////////////////////////////////////////////
	// Code-group synchronization

	// Simplified sync FSM states, in acquisition order
	typedef enum logic [1:0] {
		loss_of_sync,
		comma_1,
		comma_2,
		sync_acquired
	} sync_state_t;

endpackage

// File: design/qsgmii_lane_aligner.sv
module qsgmii_lane_aligner
	import qsgmii_pkg::*;
(
	input  logic                      rx_clk,
	input  logic                      rst_n,

	// Raw word from the transceiver, lanes in arrival order
	input  logic                      rx_data_valid,
	input  logic [port_count-1:0]     rx_data_is_ctl,
	input  logic [8*port_count-1:0]   rx_data,
	input  logic [port_count-1:0]     rx_disparity_err,
	input  logic [port_count-1:0]     rx_symbol_err,

	// Word with port g in lane g
	output logic                      port_valid,
	output logic [port_count-1:0]     port_is_ctl,
	output logic [8*port_count-1:0]   port_data,
	output logic [port_count-1:0]     port_disparity_err,
	output logic [port_count-1:0]     port_symbol_err
);

	// Input lane that currently carries port 0
	lane_idx_t                  base_lane;

	// Rotated word, before the output register
	logic [port_count-1:0]      rot_is_ctl;
	logic [8*port_count-1:0]    rot_data;
	logic [port_count-1:0]      rot_disparity_err;
	logic [port_count-1:0]      rot_symbol_err;

	// Marker found in this word, and the lane it sat in
	logic                       marker_seen;
	lane_idx_t                  marker_lane;

	//////////////////////////////////////////////////
	// Lane rotation and marker search

	always_comb begin
		lane_idx_t src;
		rot_is_ctl        = '0;
		rot_data          = '0;
		rot_disparity_err = '0;
		rot_symbol_err    = '0;
		marker_seen       = 1'b0;
		marker_lane       = base_lane;
		for (int i = 0; i < port_count; i++) begin
			// Output lane i comes from input lane (i + base_lane) mod 4
			src = lane_idx_t'(i) + base_lane;
			rot_is_ctl[i]        = rx_data_is_ctl[src];
			rot_data[i*8 +: 8]   = rx_data[src*8 +: 8];
			rot_disparity_err[i] = rx_disparity_err[src];
			rot_symbol_err[i]    = rx_symbol_err[src];
			// K28.1 marks port 0; hand it on as a plain comma
			if (rx_data_is_ctl[src] && (rx_data[src*8 +: 8] == k28_1)) begin
				rot_data[i*8 +: 8] = k28_5;
				marker_seen        = 1'b1;
				marker_lane        = src;
			end
		end
	end

	//////////////////////////////////////////////////
	// Output register and base lane tracking

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			base_lane          <= '0;
			port_valid         <= 1'b0;
			port_is_ctl        <= '0;
			port_data          <= '0;
			port_disparity_err <= '0;
			port_symbol_err    <= '0;
		end else begin
			port_valid         <= rx_data_valid;
			port_is_ctl        <= rot_is_ctl;
			port_data          <= rot_data;
			port_disparity_err <= rot_disparity_err;
			port_symbol_err    <= rot_symbol_err;
			// Only a qualified word may move the lane map
			// New base applies from the next word on
			if (rx_data_valid && marker_seen) begin
				base_lane <= marker_lane;
			end
		end
	end

endmodule

// File: design/sgmii_sync_monitor.sv
module sgmii_sync_monitor
	import qsgmii_pkg::*;
(
	input  logic         rx_clk,
	input  logic         rst_n,

	// One lane of the aligned word
	input  logic         valid,
	input  logic         is_ctl,
	input  logic [7:0]   data,
	input  logic         code_err,

	// Sync status for this port
	output logic         synced,
	output sync_state_t  state
);

	// Invalid words seen in sync since the last comma
	// Wraps to loss of sync on the fourth one
	logic [1:0]   err_run;

	// Next-state values
	sync_state_t  state_next;
	logic [1:0]   err_run_next;

	// Control K28.5 with no coding error
	logic         is_comma;

	assign is_comma = is_ctl && (data == k28_5) && !code_err;

	//////////////////////////////////////////////////
	// Next state

	always_comb begin
		state_next   = state;
		err_run_next = err_run;
		case (state)
			loss_of_sync: begin
				err_run_next = '0;
				if (is_comma) begin
					state_next = comma_1;
				end
			end
			comma_1: begin
				err_run_next = '0;
				if (code_err) begin
					state_next = loss_of_sync;
				end else if (is_comma) begin
					state_next = comma_2;
				end
			end
			comma_2: begin
				err_run_next = '0;
				if (code_err) begin
					state_next = loss_of_sync;
				end else if (is_comma) begin
					state_next = sync_acquired;
				end
			end
			sync_acquired: begin
				// Comma restarts the error run
				if (is_comma) begin
					err_run_next = '0;
				end else if (code_err) begin
					if (err_run == 2'd3) begin
						// Fourth error in a row
						state_next   = loss_of_sync;
						err_run_next = '0;
					end else begin
						err_run_next = err_run + 2'd1;
					end
				end
			end
			default: begin
				state_next   = loss_of_sync;
				err_run_next = '0;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// State register

	// Words with valid low leave everything as it was
	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= loss_of_sync;
			err_run <= '0;
		end else if (valid) begin
			state   <= state_next;
			err_run <= err_run_next;
		end
	end

	// Synced only in the acquired state
	assign synced = (state == sync_acquired);

endmodule

// File: design/sgmii_error_counters.sv
module sgmii_error_counters
	import qsgmii_pkg::*;
#(
	parameter int cnt_width = 8
) (
	input  logic                                 rx_clk,
	input  logic                                 rst_n,

	// Error flags of the aligned word, one bit per port
	input  logic                                 valid,
	input  logic [port_count-1:0]                disparity_err,
	input  logic [port_count-1:0]                symbol_err,

	// Single-cycle pulse, zeroes every counter
	input  logic                                 clear,

	// One saturating count per port
	output logic [port_count-1:0][cnt_width-1:0] err_count
);

	// Largest value a counter can hold
	localparam logic [cnt_width-1:0] cnt_max = '1;

	// Port saw any code-group error in this word
	logic [port_count-1:0]  err_hit;

	assign err_hit = disparity_err | symbol_err;

	//////////////////////////////////////////////////
	// Counters

	always_ff @(posedge rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			err_count <= '0;
		end else begin
			for (int p = 0; p < port_count; p++) begin
				// Clear beats a same-cycle increment
				if (clear) begin
					err_count[p] <= '0;
				end else if (valid && err_hit[p] && (err_count[p] != cnt_max)) begin
					err_count[p] <= err_count[p] + 1'b1;
				end
				// At full scale the count just holds
			end
		end
	end

endmodule

// File: design/qsgmii_rx_bridge.sv
module qsgmii_rx_bridge
	import qsgmii_pkg::*;
#(
	parameter int cnt_width = 8
) (
	input  logic                                 rx_clk,
	input  logic                                 rst_n,

	// Decoded word from the transceiver
	input  logic                                 rx_data_valid,
	input  logic [port_count-1:0]                rx_data_is_ctl,
	input  logic [8*port_count-1:0]              rx_data,
	input  logic [port_count-1:0]                rx_disparity_err,
	input  logic [port_count-1:0]                rx_symbol_err,

	// Error counter clear pulse
	input  logic                                 err_clear,

	// Aligned word, port g in lane g
	output logic                                 port_valid,
	output logic [port_count-1:0]                port_is_ctl,
	output logic [8*port_count-1:0]              port_data,
	output logic [port_count-1:0]                port_disparity_err,
	output logic [port_count-1:0]                port_symbol_err,

	// Per-port status
	output logic [port_count-1:0]                port_synced,
	output sync_state_t [port_count-1:0]         port_sync_state,
	output logic [port_count-1:0][cnt_width-1:0] err_count
);

	// Either kind of coding error makes a word invalid
	logic [port_count-1:0]  port_code_err;

	assign port_code_err = port_disparity_err | port_symbol_err;

	//////////////////////////////////////////////////
	// Lane alignment

	qsgmii_lane_aligner u_aligner (
		.rx_clk             (rx_clk),
		.rst_n              (rst_n),
		.rx_data_valid      (rx_data_valid),
		.rx_data_is_ctl     (rx_data_is_ctl),
		.rx_data            (rx_data),
		.rx_disparity_err   (rx_disparity_err),
		.rx_symbol_err      (rx_symbol_err),
		.port_valid         (port_valid),
		.port_is_ctl        (port_is_ctl),
		.port_data          (port_data),
		.port_disparity_err (port_disparity_err),
		.port_symbol_err    (port_symbol_err)
	);

	//////////////////////////////////////////////////
	// Per-port sync and error tracking

	for (genvar g = 0; g < port_count; g++) begin : g_sync
		sgmii_sync_monitor u_sync (
			.rx_clk   (rx_clk),
			.rst_n    (rst_n),
			.valid    (port_valid),
			.is_ctl   (port_is_ctl[g]),
			.data     (port_data[g*8 +: 8]),
			.code_err (port_code_err[g]),
			.synced   (port_synced[g]),
			.state    (port_sync_state[g])
		);
	end

	sgmii_error_counters #(
		.cnt_width (cnt_width)
	) u_err_cnt (
		.rx_clk        (rx_clk),
		.rst_n         (rst_n),
		.valid         (port_valid),
		.disparity_err (port_disparity_err),
		.symbol_err    (port_symbol_err),
		.clear         (err_clear),
		.err_count     (err_count)
	);

endmodule

// File: verif/qsgmii_rx_model.svh
`ifndef QSGMII_RX_MODEL_SVH
`define QSGMII_RX_MODEL_SVH

//////////////////////////////////////////////////
// Reference model state

// Aligned word, one step behind the inputs
lane_idx_t                m_base;
logic                     m_valid;
logic [port_count-1:0]    m_ctl;
logic [8*port_count-1:0]  m_data;
logic [port_count-1:0]    m_de;
logic [port_count-1:0]    m_se;

// Consumer view, two steps behind the inputs
sync_state_t              m_state [port_count];
int                       m_run [port_count];
logic [cnt_width-1:0]     m_cnt [port_count];

// Running total of failed checks
int                       err_total = 0;

function automatic void model_reset();
	m_base  = '0;
	m_valid = 1'b0;
	m_ctl   = '0;
	m_data  = '0;
	m_de    = '0;
	m_se    = '0;
	for (int p = 0; p < port_count; p++) begin
		m_state[p] = loss_of_sync;
		m_run[p]   = 0;
		m_cnt[p]   = '0;
	end
endfunction

// One clock of the bridge, fed with the word sampled on that edge
task automatic model_step(input logic v, input logic [port_count-1:0] ctl,
		input logic [8*port_count-1:0] d, input logic [port_count-1:0] de,
		input logic [port_count-1:0] se, input logic clr);
	lane_idx_t  dst;
	lane_idx_t  new_base;
	logic       hit;
	logic       bad;
	logic       comma;
	hit      = 1'b0;
	new_base = m_base;
	// Consumers act on the previously aligned word
	for (int p = 0; p < port_count; p++) begin
		bad   = m_de[p] | m_se[p];
		comma = m_ctl[p] && (m_data[p*8 +: 8] == k28_5) && !bad;
		if (clr)
			m_cnt[p] = '0;
		else if (m_valid && bad && (m_cnt[p] != '1))
			m_cnt[p] = m_cnt[p] + cnt_width'(1);
		if (m_valid) begin
			if (m_state[p] == sync_acquired) begin
				// Count invalid words since the last comma
				m_run[p] = comma ? 0 : m_run[p] + (bad ? 1 : 0);
				if (m_run[p] == 4) begin
					m_state[p] = loss_of_sync;
					m_run[p]   = 0;
				end
			end else if (bad && (m_state[p] != loss_of_sync)) begin
				m_state[p] = loss_of_sync;
			end else if (comma) begin
				case (m_state[p])
					loss_of_sync: m_state[p] = comma_1;
					comma_1:      m_state[p] = comma_2;
					default:      m_state[p] = sync_acquired;
				endcase
			end
		end
	end
	// Input lane j lands on output lane (j - base) mod 4
	m_valid = v;
	for (int j = 0; j < port_count; j++) begin
		dst                = lane_idx_t'(j) - m_base;
		m_ctl[dst]         = ctl[j];
		m_de[dst]          = de[j];
		m_se[dst]          = se[j];
		m_data[dst*8 +: 8] = d[j*8 +: 8];
		if (ctl[j] && (d[j*8 +: 8] == k28_1)) begin
			m_data[dst*8 +: 8] = k28_5;
			new_base           = lane_idx_t'(j);
			hit                = 1'b1;
		end
	end
	if (v && hit)
		m_base = new_base;
endtask

//////////////////////////////////////////////////
// Compare tasks

task automatic check_word(input string what, input logic [8*port_count-1:0] got,
		input logic [8*port_count-1:0] exp);
	if (got !== exp) begin
		err_total++;
		$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
	end
endtask

task automatic check_flags(input string what, input logic [port_count-1:0] got,
		input logic [port_count-1:0] exp);
	if (got !== exp) begin
		err_total++;
		$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
	end
endtask

task automatic check_state(input int port, input sync_state_t got, input sync_state_t exp);
	if (got !== exp) begin
		err_total++;
		$display("Error at %0t: port %0d state is %s, expected %s",
			$time, port, got.name(), exp.name());
	end
endtask

task automatic check_count(input int port, input logic [cnt_width-1:0] got,
		input logic [cnt_width-1:0] exp);
	if (got !== exp) begin
		err_total++;
		$display("Error at %0t: port %0d count is %0d, expected %0d", $time, port, got, exp);
	end
endtask

`endif

// File: verif/qsgmii_rx_bridge_tb.sv
module qsgmii_rx_bridge_tb
	import qsgmii_pkg::*;
();

	// Narrow counters so saturation is reached quickly
	localparam int cnt_width  = 4;
	localparam int clk_period = 40;
	// Reset and each test in clock cycles
	localparam int test_cycles = 10 + 59 + 15 + 31 + 25 + 153 + 15;

	logic                                  rx_clk;
	logic                                  rst_n;
	logic                                  rx_data_valid;
	logic [port_count-1:0]                 rx_data_is_ctl;
	logic [8*port_count-1:0]               rx_data;
	logic [port_count-1:0]                 rx_disparity_err;
	logic [port_count-1:0]                 rx_symbol_err;
	logic                                  err_clear;
	logic                                  port_valid;
	logic [port_count-1:0]                 port_is_ctl;
	logic [8*port_count-1:0]               port_data;
	logic [port_count-1:0]                 port_disparity_err;
	logic [port_count-1:0]                 port_symbol_err;
	logic [port_count-1:0]                 port_synced;
	sync_state_t [port_count-1:0]          port_sync_state;
	logic [port_count-1:0][cnt_width-1:0]  err_count;

	int  seed = 32'ha43a_faf2;
	int  pass_count = 0;
	int  fail_count = 0;
	int  test_errs = 0;
	int  sync_port = 0;

	`include "qsgmii_rx_model.svh"

	qsgmii_rx_bridge #(.cnt_width(cnt_width)) dut (.*);

	initial begin
		rx_clk = 1'b0;
		forever #(clk_period / 2) rx_clk = ~rx_clk;
	end

	initial begin
		#((test_cycles + 100) * clk_period);
		$display("Timeout: the tests did not finish within %0d cycles", test_cycles + 100);
		$display("FAIL: see errors above");
		$finish;
	end

	//////////////////////////////////////////////////
	// Cycle checker on the falling edge where outputs are stable

	always @(negedge rx_clk) begin
		logic [port_count-1:0] exp_synced;
		if (rst_n !== 1'b1) begin
			model_reset();
		end else begin
			check_flags("port_valid", {3'b000, port_valid}, {3'b000, m_valid});
			check_word("port_data", port_data, m_data);
			check_flags("port_is_ctl", port_is_ctl, m_ctl);
			check_flags("port_disparity_err", port_disparity_err, m_de);
			check_flags("port_symbol_err", port_symbol_err, m_se);
			for (int p = 0; p < port_count; p++) begin
				exp_synced[p] = (m_state[p] == sync_acquired);
				check_state(p, port_sync_state[p], m_state[p]);
				check_count(p, err_count[p], m_cnt[p]);
			end
			check_flags("port_synced", port_synced, exp_synced);
			// Word on the pins now is taken at the next rising edge
			model_step(rx_data_valid, rx_data_is_ctl, rx_data, rx_disparity_err,
				rx_symbol_err, err_clear);
		end
	end

	//////////////////////////////////////////////////
	// Stimulus helpers

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic logic [31:0] with_byte(input logic [31:0] w, input int lane,
			input logic [7:0] b);
		w[lane*8 +: 8] = b;
		return w;
	endfunction

	task automatic send(input logic v, input logic [3:0] ctl, input logic [31:0] d,
			input logic [3:0] de, input logic [3:0] se, input logic clr);
		@(posedge rx_clk);
		rx_data_valid    <= v;
		rx_data_is_ctl   <= ctl;
		rx_data          <= d;
		rx_disparity_err <= de;
		rx_symbol_err    <= se;
		err_clear        <= clr;
	endtask

	task automatic send_data(input int n);
		repeat (n) send(1'b1, '0, rand32(), '0, '0, 1'b0);
	endtask

	task automatic idle(input int n);
		repeat (n) send(1'b0, '0, '0, '0, '0, 1'b0);
	endtask

	task automatic send_comma(input int p);
		send(1'b1, 4'b0001 << p, with_byte(rand32(), p, k28_5), '0, '0, 1'b0);
	endtask

	task automatic send_err(input int p);
		send(1'b1, '0, rand32(), 4'b0001 << p, '0, 1'b0);
	endtask

	task automatic apply_reset();
		@(posedge rx_clk);
		rst_n <= 1'b0;
		repeat (10) @(posedge rx_clk);
		rst_n <= 1'b1;
	endtask

	// Port under test in state exp and every other port out of sync
	task automatic expect_states(input int port, input sync_state_t exp);
		@(negedge rx_clk);
		for (int p = 0; p < port_count; p++)
			check_state(p, port_sync_state[p], (p == port) ? exp : loss_of_sync);
	endtask

	task automatic expect_counts(input logic [cnt_width-1:0] exp);
		@(negedge rx_clk);
		for (int p = 0; p < port_count; p++)
			check_count(p, err_count[p], exp);
	endtask

	// Drain the pipeline before reporting the test
	task automatic finish_test(input string name);
		idle(3);
		if (err_total == test_errs) begin
			pass_count++;
			$display("Test %s passed", name);
		end else begin
			fail_count++;
			$display("Test %s failed with %0d errors", name, err_total - test_errs);
		end
		test_errs = err_total;
	endtask

	//////////////////////////////////////////////////
	// Tests

	task automatic test_alignment();
		int lane;
		repeat (8) begin
			lane = rand32() & 3;
			send(1'b1, 4'b0001 << lane, with_byte(rand32(), lane, k28_1), '0, '0, 1'b0);
			send_data(6);
		end
		finish_test("alignment");
	endtask

	task automatic test_marker();
		int lane;
		repeat (6) begin
			lane = rand32() & 3;
			// Data bytes of 8'h3c around the control marker
			send(1'b1, 4'b0001 << lane, {4{k28_1}}, '0, '0, 1'b0);
			send(1'b1, '0, {4{k28_1}}, '0, '0, 1'b0);
		end
		finish_test("marker_restore");
	endtask

	task automatic test_sync_acquire();
		apply_reset();
		send_data(8);
		sync_port = rand32() & 3;
		repeat (3) begin
			send_comma(sync_port);
			send_data(1);
		end
		idle(2);
		expect_states(sync_port, sync_acquired);
		finish_test("sync_acquire");
	endtask

	task automatic test_sync_loss();
		repeat (3) send_err(sync_port);
		send_comma(sync_port);
		repeat (3) send_err(sync_port);
		idle(2);
		expect_states(sync_port, sync_acquired);
		send_err(sync_port);
		idle(2);
		expect_states(sync_port, loss_of_sync);
		send_comma(sync_port);
		idle(2);
		expect_states(sync_port, comma_1);
		send_err(sync_port);
		idle(2);
		expect_states(sync_port, loss_of_sync);
		finish_test("sync_loss");
	endtask

	task automatic test_counters();
		logic [31:0] r;
		repeat (120) begin
			r = rand32();
			send(r[31] | r[30], '0, rand32(), r[3:0], r[7:4], r[29] & r[28] & r[27] & r[26]);
		end
		repeat (20) send(1'b1, '0, rand32(), 4'hf, '0, 1'b0);
		idle(2);
		expect_counts('1);
		// Back below full scale so a lost clear would show as a count
		send(1'b1, '0, rand32(), '0, '0, 1'b1);
		send(1'b1, '0, rand32(), 4'hf, '0, 1'b0);
		// Clear lands on the same edge as an all-error word
		send(1'b1, '0, rand32(), 4'hf, 4'hf, 1'b0);
		send(1'b1, '0, rand32(), '0, '0, 1'b1);
		idle(2);
		expect_counts('0);
		finish_test("error_counters");
	endtask

	task automatic test_valid_gating();
		int          lane;
		logic [3:0]  errs;
		for (int i = 0; i < 6; i++) begin
			lane = rand32() & 3;
			// Clean commas on even words would start sync if not gated
			errs = (i % 2) ? 4'hf : 4'h0;
			send(1'b0, 4'hf, with_byte({4{k28_5}}, lane, k28_1), errs, errs, 1'b0);
		end
		send_data(6);
		finish_test("valid_gating");
	endtask

	initial begin
		rst_n            = 1'b0;
		rx_data_valid    = 1'b0;
		rx_data_is_ctl   = '0;
		rx_data          = '0;
		rx_disparity_err = '0;
		rx_symbol_err    = '0;
		err_clear        = 1'b0;
		repeat (10) @(posedge rx_clk);
		rst_n <= 1'b1;
		test_alignment();
		test_marker();
		test_sync_acquire();
		test_sync_loss();
		test_counters();
		test_valid_gating();
		$display("Tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, err_total);
		if (fail_count == 0 && err_total == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+verif
design/qsgmii_pkg.sv
design/qsgmii_lane_aligner.sv
design/sgmii_sync_monitor.sv
design/sgmii_error_counters.sv
design/qsgmii_rx_bridge.sv
verif/qsgmii_rx_bridge_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = qsgmii_rx_bridge_tb
FILELIST = filelist.f
PASS_MSG = PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F -x "$(PASS_MSG)" > /dev/null

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
